//--- gte.f
rtl/gteRegPkg.sv
rtl/gteCmdPkg.sv
rtl/gteRegFile.sv
rtl/gteMulAcc.sv
rtl/gteCmdSeq.sv
rtl/gteTop.sv
tests/gteTb.sv

//--- run.sh
#!/bin/sh
# Build and run the GTE testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module gteTb \
    --Mdir obj_dir \
    -o gteSim \
    -f gte.f

./obj_dir/gteSim > sim.log 2>&1
cat sim.log

if grep -q "STATUS: PASS" sim.log; then
    exit 0
else
    exit 1
fi

//--- tests/gteTb.sv
`default_nettype none

module gteTb
    import gteRegPkg::*;
    import gteCmdPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NumWrites = 16;
    localparam int NumRand = 4;
    // Worst case of five writes, a command, two reads and some slack
    localparam int CaseCycles = 8 + LenNclip;
    // Reset, reset readout, readback, then all command cases
    localparam int TestCycles = 8 + 2 * BankSize + 2 * NumWrites
        + (2 * (NumRand + 3) + NumRand + 2) * CaseCycles;
    localparam int CycleLimit = 2 * TestCycles;

    logic clk;
    logic rst;
    logic we;
    logic wrCtrl;
    regIdx wrIdx;
    regWord wrData;
    logic rdCtrl;
    regIdx rdIdx;
    regWord rdData;
    logic cmdStart;
    logic [5:0] opCode;
    logic busy;
    logic done;

    int errors = 0;
    int checks = 0;
    int errAtStart = 0;
    int cycles = 0;
    logic [31:0] lfsrState = 32'h2922_2cac;
    // OTZ as left by the last AVSZ case
    regWord otzExp = '0;

    gteTop uut (
        .clk(clk), .rst(rst),
        .we(we), .wrCtrl(wrCtrl), .wrIdx(wrIdx), .wrData(wrData),
        .rdCtrl(rdCtrl), .rdIdx(rdIdx), .rdData(rdData),
        .cmdStart(cmdStart), .cmdOp(opCode), .busy(busy), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Hard stop in case a wait never ends
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CycleLimit) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // done only inside busy, and never two cycles long
    assert property (@(posedge clk) disable iff (rst) done |-> busy)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: busy expected 1 actual 0", $time);
        end
    assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: done expected 0 actual 1", $time);
        end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    // Low 32 bits of the signed weight times the unsigned Z sum
    function automatic logic [31:0] avszModel(logic [15:0] zsf, logic [15:0] z0,
                                              logic [15:0] z1, logic [15:0] z2,
                                              logic [15:0] z3);
        longint p;
        p = longint'($signed(zsf)) * (longint'(z0) + longint'(z1) + longint'(z2)
            + longint'(z3));
        return p[31:0];
    endfunction

    // MAC0 >>> 12 limited to 0..0xFFFF
    function automatic logic [31:0] otzModel(logic [31:0] mac);
        int m;
        m = $signed(mac) >>> OtzShift;
        if (m < 0) begin
            return 32'd0;
        end else if (m > 65535) begin
            return 32'h0000_FFFF;
        end else begin
            return m;
        end
    endfunction

    // Winding determinant with SX in the low half and SY in the high half
    function automatic logic [31:0] nclipModel(logic [31:0] w0, logic [31:0] w1,
                                               logic [31:0] w2);
        longint x0, x1, x2, y0, y1, y2, d;
        x0 = longint'($signed(w0[15:0]));
        x1 = longint'($signed(w1[15:0]));
        x2 = longint'($signed(w2[15:0]));
        y0 = longint'($signed(w0[31:16]));
        y1 = longint'($signed(w1[31:16]));
        y2 = longint'($signed(w2[31:16]));
        d = x0 * y1 + x1 * y2 + x2 * y0 - x0 * y2 - x1 * y0 - x2 * y1;
        return d[31:0];
    endfunction

    // Back to the drive slot after the next edge
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic writeReg(logic ctrl, regIdx idx, regWord data);
        we = 1'b1;
        wrCtrl = ctrl;
        wrIdx = idx;
        wrData = data;
        nextCycle();
        we = 1'b0;
    endtask

    // Sample mid-cycle, then move on one cycle
    task automatic readReg(logic ctrl, regIdx idx, output regWord data);
        rdCtrl = ctrl;
        rdIdx = idx;
        #1;
        data = rdData;
        nextCycle();
    endtask

    task automatic checkVal(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        assert (actual === expected)
            else begin
                errors++;
                $display("CHECK FAILED at %0t: %s expected %h actual %h",
                         $time, name, expected, actual);
            end
    endtask

    task automatic endTest(string name);
        $display("%s test finished, %0d errors", name, errors - errAtStart);
        errAtStart = errors;
    endtask

    // Pulse cmdStart, count edges to done, read results while done is high
    task automatic runCmd(logic [5:0] op, int len, logic [31:0] expMac,
                          logic [31:0] expOtz);
        int n;
        regWord v;
        opCode = op;
        cmdStart = 1'b1;
        nextCycle();
        cmdStart = 1'b0;
        n = 1;
        while (!done && n < len + 4) begin
            // busy holds from the accepting edge on
            checkVal("busy", 1, busy);
            nextCycle();
            n++;
        end
        if (!done) begin
            errors++;
            $display("Command %h gave no done pulse within %0d cycles", op, len + 4);
        end else begin
            checkVal("done latency", len, n);
            checkVal("busy", 1, busy);
            readReg(1'b0, IdxMac0, v);
            checkVal("MAC0", expMac, v);
            // busy falls with the end of done
            checkVal("busy", 0, busy);
            checkVal("done", 0, done);
            readReg(1'b0, IdxOtz, v);
            checkVal("OTZ", expOtz, v);
        end
    endtask

    // All four SZ written so that AVSZ3 has to skip SZ0
    task automatic avszCase(logic four, regWord zsfW, regWord s0, regWord s1,
                            regWord s2, regWord s3);
        logic [31:0] mac;
        writeReg(1'b0, IdxSz0, s0);
        writeReg(1'b0, IdxSz1, s1);
        writeReg(1'b0, IdxSz2, s2);
        writeReg(1'b0, IdxSz3, s3);
        if (four) begin
            writeReg(1'b1, IdxZsf4, zsfW);
            mac = avszModel(zsfW[15:0], s0[15:0], s1[15:0], s2[15:0], s3[15:0]);
            otzExp = otzModel(mac);
            runCmd(OpAvsz4, LenAvsz4, mac, otzExp);
        end else begin
            writeReg(1'b1, IdxZsf3, zsfW);
            mac = avszModel(zsfW[15:0], 16'd0, s1[15:0], s2[15:0], s3[15:0]);
            otzExp = otzModel(mac);
            runCmd(OpAvsz3, LenAvsz3, mac, otzExp);
        end
    endtask

    // NCLIP leaves OTZ at the value of the last AVSZ case
    task automatic nclipCase(regWord w0, regWord w1, regWord w2);
        writeReg(1'b0, IdxSxy0, w0);
        writeReg(1'b0, IdxSxy1, w1);
        writeReg(1'b0, IdxSxy2, w2);
        runCmd(OpNclip, LenNclip, nclipModel(w0, w1, w2), otzExp);
    endtask

    initial begin
        regWord v;
        regWord w;
        logic c;
        regIdx idx;
        logic [31:0] expMac;
        int n;
        int pulses;
        int doneAt;

        rst = 1'b1;
        we = 1'b0;
        wrCtrl = 1'b0;
        wrIdx = '0;
        wrData = '0;
        rdCtrl = 1'b0;
        rdIdx = '0;
        cmdStart = 1'b0;
        opCode = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle strobes and cleared banks
        checkVal("busy", 0, busy);
        checkVal("done", 0, done);
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < BankSize; i++) begin
                readReg(b[0], regIdx'(i), v);
                checkVal($sformatf("bank%0d[%0d]", b, i), 0, v);
            end
        end
        endTest("reset");

        for (int i = 0; i < NumWrites; i++) begin
            c = 1'(randBits(1));
            idx = regIdx'(randBits(5));
            w = randBits(32);
            writeReg(c, idx, w);
            readReg(c, idx, v);
            checkVal($sformatf("bank%0d[%0d]", c, idx), w, v);
        end
        endTest("readback");

        for (int k = 0; k < 2; k++) begin
            for (int i = 0; i < NumRand; i++) begin
                avszCase(k[0], randBits(32), randBits(32), randBits(32),
                         randBits(32), randBits(32));
            end
            // Typical weight keeps OTZ inside its range
            avszCase(k[0], 32'h0000_0155, 32'h1234, 32'h2345, 32'h3456, 32'h4567);
            // Negative weight clamps to 0 and a big sum to 0xFFFF
            avszCase(k[0], 32'h0000_F000, 32'd100, 32'd100, 32'd100, 32'd100);
            avszCase(k[0], 32'h0000_1000, 32'hFFFF, 32'hFFFF, 32'hFFFF, 32'hFFFF);
            endTest(k == 0 ? "AVSZ3" : "AVSZ4");
        end

        for (int i = 0; i < NumRand; i++) begin
            nclipCase(randBits(32), randBits(32), randBits(32));
        end
        endTest("NCLIP");

        // Unknown opcodes
        for (int k = 0; k < 2; k++) begin
            opCode = (k == 0) ? 6'h01 : 6'h2F;
            cmdStart = 1'b1;
            nextCycle();
            cmdStart = 1'b0;
            repeat (LenNclip) begin
                checkVal("busy", 0, busy);
                checkVal("done", 0, done);
                nextCycle();
            end
        end

        // NCLIP start while AVSZ4 runs is dropped
        w = randBits(32);
        writeReg(1'b0, IdxSz0, w);
        writeReg(1'b0, IdxSz1, ~w);
        writeReg(1'b0, IdxSz2, {w[15:0], w[31:16]});
        writeReg(1'b0, IdxSz3, w ^ 32'h5a5a_5a5a);
        writeReg(1'b1, IdxZsf4, 32'h0000_0123);
        expMac = avszModel(16'h0123, w[15:0], ~w[15:0], w[31:16], w[15:0] ^ 16'h5a5a);
        opCode = OpAvsz4;
        cmdStart = 1'b1;
        nextCycle();
        opCode = OpNclip;
        nextCycle();
        cmdStart = 1'b0;
        n = 2;
        pulses = 0;
        doneAt = 0;
        repeat (LenNclip + 4) begin
            if (done) begin
                pulses++;
                if (doneAt == 0) begin
                    doneAt = n;
                end
            end
            nextCycle();
            n++;
        end
        checkVal("done pulses", 1, pulses);
        checkVal("done latency", LenAvsz4, doneAt);
        readReg(1'b0, IdxMac0, v);
        checkVal("MAC0", expMac, v);
        readReg(1'b0, IdxOtz, v);
        checkVal("OTZ", otzModel(expMac), v);
        endTest("ignored");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/gteTop.sv
`default_nettype none

module gteTop
    import gteRegPkg::*;
    import gteCmdPkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            we,
    input  logic            wrCtrl,
    input  regIdx           wrIdx,
    input  regWord          wrData,
    input  logic            rdCtrl,
    input  regIdx           rdIdx,
    input  logic            cmdStart,
    input  gteCmdPkg::cmdOp cmdOp,
    output regWord          rdData,
    output logic            busy,
    output logic            done
);

    // Register file to sequencer
    coord  sx [3];
    coord  sy [3];
    depth  sz [4];
    zScale zsf3;
    zScale zsf4;

    // Sequencer to MAC
    logic       mulEn;
    prodOperand opA;
    prodOperand opB;
    accMode     mode;
    logic signed [AccWidth-1:0] acc;

    // Result writeback
    logic   mac0We;
    regWord mac0Value;
    logic   otzWe;
    depth   otzValue;

    gteRegFile regFile (
        .clk(clk), .rst(rst),
        .we(we), .wrCtrl(wrCtrl), .wrIdx(wrIdx), .wrData(wrData),
        .rdCtrl(rdCtrl), .rdIdx(rdIdx),
        .mac0We(mac0We), .mac0Value(mac0Value), .otzWe(otzWe), .otzValue(otzValue),
        .rdData(rdData),
        .sx(sx), .sy(sy), .sz(sz), .zsf3(zsf3), .zsf4(zsf4)
    );

    gteMulAcc mulAcc (
        .clk(clk), .rst(rst),
        .mulEn(mulEn), .opA(opA), .opB(opB), .mode(mode),
        .acc(acc)
    );

    gteCmdSeq cmdSeq (
        .clk(clk), .rst(rst),
        .cmdStart(cmdStart), .cmdOp(cmdOp), .acc(acc),
        .sx(sx), .sy(sy), .sz(sz), .zsf3(zsf3), .zsf4(zsf4),
        .busy(busy), .done(done),
        .mulEn(mulEn), .opA(opA), .opB(opB), .mode(mode),
        .mac0We(mac0We), .mac0Value(mac0Value), .otzWe(otzWe), .otzValue(otzValue)
    );

endmodule

`default_nettype wire

//--- rtl/gteCmdSeq.sv
`default_nettype none

module gteCmdSeq
    import gteRegPkg::*;
    import gteCmdPkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmdStart,
    input  gteCmdPkg::cmdOp            cmdOp,
    input  logic signed [AccWidth-1:0] acc,
    input  coord                       sx [3],
    input  coord                       sy [3],
    input  depth                       sz [4],
    input  zScale                      zsf3,
    input  zScale                      zsf4,
    output logic                       busy,
    output logic                       done,
    output logic                       mulEn,
    output prodOperand                 opA,
    output prodOperand                 opB,
    output accMode                     mode,
    output logic                       mac0We,
    output regWord                     mac0Value,
    output logic                       otzWe,
    output depth                       otzValue
);

    // Latched opcode of the running command
    gteCmdPkg::cmdOp opReg;
    stepCnt          step;

    logic            accept;
    logic            run;
    gteCmdPkg::cmdOp curOp;
    stepCnt          curStep;
    stepCnt          prodCnt;
    stepCnt          lastStep;
    accMode          prodMode;
    logic [1:0]      szSel;
    // NCLIP pair, SX select in 3:2, SY select in 1:0
    logic [3:0]      pairSel;
    // MAC0 bits that survive the arithmetic shift
    logic [31-OtzShift:0] otzRaw;

    // Step 0 is the cmdStart cycle itself, so the first product issues at once
    assign accept  = cmdStart && !busy && isCmd(cmdOp);
    assign run     = accept || (busy && !done);
    assign curOp   = busy ? opReg : cmdOp;
    assign curStep = busy ? step : '0;

    // P products, then drain, then writeback
    assign prodCnt  = stepCnt'(cmdLen(curOp) - 2);
    assign lastStep = stepCnt'(cmdLen(opReg) - 1);
    assign mulEn    = run && (curStep < prodCnt);

    // Step counter and busy/done strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            step  <= '0;
            opReg <= '0;
        end else if (accept) begin
            busy  <= 1'b1;
            step  <= 3'd1;
            opReg <= cmdOp;
        end else if (done) begin
            // Done cycle is the last busy cycle
            busy <= 1'b0;
            done <= 1'b0;
        end else if (busy) begin
            if (step == lastStep) begin
                done <= 1'b1;
            end else begin
                step <= step + 3'd1;
            end
        end
    end

    // AVSZ3 starts at SZ1, AVSZ4 at SZ0
    assign szSel = curStep[1:0] + ((curOp == OpAvsz3) ? 2'd1 : 2'd0);

    // Cross products of the determinant, added half first
    always_comb begin
        case (curStep)
            3'd0:    pairSel = {2'd0, 2'd1};
            3'd1:    pairSel = {2'd1, 2'd2};
            3'd2:    pairSel = {2'd2, 2'd0};
            3'd3:    pairSel = {2'd0, 2'd2};
            3'd4:    pairSel = {2'd1, 2'd0};
            3'd5:    pairSel = {2'd2, 2'd1};
            default: pairSel = {2'd0, 2'd0};
        endcase
    end

    // Operand mux, everything widened to 17 bits
    always_comb begin
        case (curOp)
            OpAvsz3: begin
                opA = prodOperand'(zsf3);
                opB = prodOperand'({1'b0, sz[szSel]});
            end
            OpAvsz4: begin
                opA = prodOperand'(zsf4);
                opB = prodOperand'({1'b0, sz[szSel]});
            end
            OpNclip: begin
                opA = prodOperand'(sx[pairSel[3:2]]);
                opB = prodOperand'(sy[pairSel[1:0]]);
            end
            default: begin
                opA = '0;
                opB = '0;
            end
        endcase
    end

    // Mode of the product issued this step
    always_comb begin
        if (curStep == '0) begin
            prodMode = AccClear;
        end else if ((curOp == OpNclip) && (curStep >= NclipSubStep)) begin
            prodMode = AccSub;
        end else begin
            prodMode = AccAdd;
        end
    end

    // Delayed by one edge to line up with the product register
    always_ff @(posedge clk) begin
        if (rst) begin
            mode <= AccHold;
        end else if (mulEn) begin
            mode <= prodMode;
        end else begin
            mode <= AccHold;
        end
    end

    // Writeback step, acc already holds the last product
    assign mac0We    = busy && !done && (step == lastStep);
    assign mac0Value = acc[31:0];
    assign otzWe     = mac0We && (opReg != OpNclip);

    // MAC0 >>> OtzShift, upper bits only
    assign otzRaw = acc[31:OtzShift];

    // Clamp to 0 .. OtzMax
    always_comb begin
        if (otzRaw[$high(otzRaw)]) begin
            otzValue = '0;
        end else if (|otzRaw[$high(otzRaw)-1:$bits(depth)]) begin
            otzValue = OtzMax;
        end else begin
            otzValue = otzRaw[$bits(depth)-1:0];
        end
    end

endmodule

`default_nettype wire

//--- rtl/gteMulAcc.sv
`default_nettype none

module gteMulAcc
    import gteRegPkg::*;
    import gteCmdPkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       mulEn,
    input  prodOperand                 opA,
    input  prodOperand                 opB,
    // Applies to the product registered on the previous edge
    input  accMode                     mode,
    output logic signed [AccWidth-1:0] acc
);

    localparam int ProdWidth = 2 * $bits(prodOperand);

    // Stage 1, product register
    logic signed [ProdWidth-1:0] prodReg;
    // Product widened to the accumulator, sign kept
    logic signed [AccWidth-1:0]  prodExt;

    // Loads only on an issue cycle
    always_ff @(posedge clk) begin
        if (mulEn) begin
            prodReg <= opA * opB;
        end
    end

    assign prodExt = prodReg;

    // Stage 2, running sum
    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else begin
            case (mode)
                // First product of a command replaces the old sum
                AccClear: acc <= prodExt;
                AccAdd:   acc <= acc + prodExt;
                AccSub:   acc <= acc - prodExt;
                default:  acc <= acc;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/gteRegFile.sv
`default_nettype none

module gteRegFile
    import gteRegPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    // Host write port
    input  logic   we,
    input  logic   wrCtrl,
    input  regIdx  wrIdx,
    input  regWord wrData,
    // Host read port
    input  logic   rdCtrl,
    input  regIdx  rdIdx,
    // Command results
    input  logic   mac0We,
    input  regWord mac0Value,
    input  logic   otzWe,
    input  depth   otzValue,
    output regWord rdData,
    // Unpacked operands for the sequencer
    output coord   sx [3],
    output coord   sy [3],
    output depth   sz [4],
    output zScale  zsf3,
    output zScale  zsf4
);

    // Data bank (cop2d) and control bank (cop2c)
    regWord dataBank [BankSize];
    regWord ctrlBank [BankSize];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BankSize; i++) begin
                dataBank[i] <= '0;
                ctrlBank[i] <= '0;
            end
        end else begin
            // Host side
            if (we && wrCtrl) begin
                ctrlBank[wrIdx] <= wrData;
            end
            if (we && !wrCtrl) begin
                dataBank[wrIdx] <= wrData;
            end
            // Results come last so they win on a collision
            if (mac0We) begin
                dataBank[IdxMac0] <= mac0Value;
            end
            // OTZ is zero-extended, upper half reads as zero
            if (otzWe) begin
                dataBank[IdxOtz] <= regWord'(otzValue);
            end
        end
    end

    // Combinational read, no latency
    assign rdData = rdCtrl ? ctrlBank[rdIdx] : dataBank[rdIdx];

    // SXYn: SX in bits 15:0, SY in bits 31:16
    assign sx[0] = dataBank[IdxSxy0][15:0];
    assign sy[0] = dataBank[IdxSxy0][31:16];
    assign sx[1] = dataBank[IdxSxy1][15:0];
    assign sy[1] = dataBank[IdxSxy1][31:16];
    assign sx[2] = dataBank[IdxSxy2][15:0];
    assign sy[2] = dataBank[IdxSxy2][31:16];

    // Z FIFO entries, low half only
    assign sz[0] = dataBank[IdxSz0][15:0];
    assign sz[1] = dataBank[IdxSz1][15:0];
    assign sz[2] = dataBank[IdxSz2][15:0];
    assign sz[3] = dataBank[IdxSz3][15:0];

    // Weights for AVSZ3/AVSZ4
    assign zsf3 = ctrlBank[IdxZsf3][15:0];
    assign zsf4 = ctrlBank[IdxZsf4][15:0];

endmodule

`default_nettype wire

//--- rtl/gteCmdPkg.sv
`default_nettype none

package gteCmdPkg;

    // Low six bits of the coprocessor instruction
    typedef logic [5:0] cmdOp;

    localparam cmdOp OpNclip = 6'h06;
    localparam cmdOp OpAvsz3 = 6'h2D;
    localparam cmdOp OpAvsz4 = 6'h2E;

    // Step number inside a running command
    typedef logic [2:0] stepCnt;

    // What the accumulator does with the registered product
    typedef enum logic [1:0] {AccClear, AccAdd, AccSub, AccHold} accMode;

    // Cycles from cmdStart to done, products plus drain plus writeback
    localparam int LenAvsz3 = 5;
    localparam int LenAvsz4 = 6;
    localparam int LenNclip = 8;

    // NCLIP products from this index on are subtracted
    localparam stepCnt NclipSubStep = 3'd3;

    // Command length, zero for unsupported codes
    function automatic int cmdLen(cmdOp op);
        case (op)
            OpAvsz3: return LenAvsz3;
            OpAvsz4: return LenAvsz4;
            OpNclip: return LenNclip;
            default: return 0;
        endcase
    endfunction

    function automatic logic isCmd(cmdOp op);
        return cmdLen(op) != 0;
    endfunction

endpackage

`default_nettype wire

//--- rtl/gteRegPkg.sv
`default_nettype none

package gteRegPkg;

    // Raw 32-bit register word, same for both banks
    typedef logic [31:0] regWord;
    // Register number inside one bank
    typedef logic [4:0] regIdx;

    // Screen coordinate halves of SXY0..2
    typedef logic signed [15:0] coord;
    // Z values, SZ0..3 and OTZ
    typedef logic [15:0] depth;
    // Average-Z weights ZSF3/ZSF4
    typedef logic signed [15:0] zScale;

    // One bit wider than the 16-bit fields so unsigned depths stay positive
    typedef logic signed [16:0] prodOperand;

    // Running sum width in the MAC path
    localparam int AccWidth = 64;
    // Entries per bank
    localparam int BankSize = 32;

    // Data bank
    localparam regIdx IdxOtz  = 5'd7;
    localparam regIdx IdxSxy0 = 5'd12;
    localparam regIdx IdxSxy1 = 5'd13;
    localparam regIdx IdxSxy2 = 5'd14;
    localparam regIdx IdxSz0  = 5'd16;
    localparam regIdx IdxSz1  = 5'd17;
    localparam regIdx IdxSz2  = 5'd18;
    localparam regIdx IdxSz3  = 5'd19;
    localparam regIdx IdxMac0 = 5'd24;

    // Control bank
    localparam regIdx IdxZsf3 = 5'd29;
    localparam regIdx IdxZsf4 = 5'd30;

    // OTZ = limit(MAC0 >> 12)
    localparam int OtzShift = 12;
    localparam depth OtzMax = 16'hFFFF;

endpackage

`default_nettype wire
